// ==== sources.f ====
+incdir+include
design/tomasulo_pkg.sv
design/rename_table.sv
design/reservation_station.sv
design/dispatch_ctrl.sv
design/cdb_arbiter.sv
design/tomasulo_issue_top.sv
verification/tomasulo_issue_tb.sv

// ==== include/tomasulo_tb_model.svh ====
`ifndef TOMASULO_TB_MODEL_SVH
`define TOMASULO_TB_MODEL_SVH

// program layout: random mix, ready burst, random under busy, final readout
localparam int PROG_LEN = 96;
localparam int BURST_AT = 40;
localparam int HOLD_AT  = 60;
localparam int FINAL_AT = 80;

instr_t             prog     [PROG_LEN];
logic [`DATA_W-1:0] exp_a    [PROG_LEN];
logic [`DATA_W-1:0] exp_b    [PROG_LEN];
logic [`DATA_W-1:0] exp_res  [PROG_LEN];
logic [`DATA_W-1:0] ref_regs [`NUM_REGS];

function automatic logic [`DATA_W-1:0] mem_word(input logic [`DATA_W-1:0] addr);
  return addr * 3 + 7;
endfunction

function automatic logic [`DATA_W-1:0] unit_result(input opcode_t op,
                                                   input logic [`DATA_W-1:0] a,
                                                   input logic [`DATA_W-1:0] b);
  case (op)
    OP_ADD:  return a + b;
    OP_SUB:  return a - b;
    OP_AND:  return a & b;
    OP_XOR:  return a ^ b;
    default: return mem_word(a + b);
  endcase
endfunction

function automatic instr_t make_alu(input opcode_t op, input logic [`REG_W-1:0] rd,
                                    input logic [`REG_W-1:0] rs1,
                                    input logic [`REG_W-1:0] rs2);
  instr_t w;
  w.alu.opcode = op;
  w.alu.rd     = rd;
  w.alu.rs1    = rs1;
  w.alu.rs2    = rs2;
  w.alu.spare  = '0;
  return w;
endfunction

function automatic instr_t make_ld(input logic [`REG_W-1:0] rd,
                                   input logic [`REG_W-1:0] base,
                                   input logic [OFFSET_W-1:0] offset);
  instr_t w;
  w.ld.opcode = OP_LD;
  w.ld.rd     = rd;
  w.ld.base   = base;
  w.ld.offset = offset;
  return w;
endfunction

// r0 is never a random destination, so it stays zero
task automatic build_program();
  logic [31:0]       r;
  logic [`REG_W-1:0] rd;
  for (int i = 0; i < PROG_LEN; i++) begin
    r  = $random(seed);
    rd = `REG_W'(1 + int'(r[7:4]) % 15);
    if (i >= FINAL_AT) begin
      prog[i] = make_alu(OP_ADD, `REG_W'(i - FINAL_AT), `REG_W'(i - FINAL_AT), '0);
    end else if (i >= BURST_AT && i < HOLD_AT) begin
      prog[i] = make_alu(OP_XOR, rd, '0, '0);
    end else if (r[2:0] % 5 == 4) begin
      prog[i] = make_ld(rd, r[11:8], r[16:12]);
    end else begin
      prog[i] = make_alu(opcode_t'(r[2:0] % 5), rd, r[11:8], r[15:12]);
    end
  end
endtask

// in-order execution gives operands and result per dispatch index
task automatic run_reference();
  instr_t w;
  for (int k = 0; k < `NUM_REGS; k++) begin
    ref_regs[k] = '0;
  end
  for (int i = 0; i < PROG_LEN; i++) begin
    w = prog[i];
    if (w.alu.opcode == OP_LD) begin
      exp_a[i] = ref_regs[w.ld.base];
      exp_b[i] = `DATA_W'(w.ld.offset);
    end else begin
      exp_a[i] = ref_regs[w.alu.rs1];
      exp_b[i] = ref_regs[w.alu.rs2];
    end
    exp_res[i] = unit_result(w.alu.opcode, exp_a[i], exp_b[i]);
    ref_regs[w.alu.rd] = exp_res[i];
  end
endtask

`endif

// ==== verification/tomasulo_issue_tb.sv ====
`timescale 1ns/100ps
`include "tomasulo_settings.svh"

module tomasulo_issue_tb import tomasulo_pkg::*; ();

  localparam int LIMIT = 300;

  logic clk, rst, dispatch_valid, alu_busy, ld_busy, alu_done, ld_done;
  instr_t dispatch_instr;
  logic [`TAG_W-1:0] alu_done_tag, ld_done_tag, alu_issue_tag, ld_issue_tag, cdb_tag;
  logic [`DATA_W-1:0] alu_done_value, ld_done_value, cdb_value;
  logic [`DATA_W-1:0] alu_issue_a, alu_issue_b, ld_issue_a, ld_issue_b;
  logic dispatch_stall, alu_issue_valid, ld_issue_valid, alu_taken, ld_taken, cdb_valid;
  opcode_t alu_issue_op;

  integer seed = 32'h488d7b69;

  `include "tomasulo_tb_model.svh"

  int errors, timeouts, cycle, dispatched, bcast_count, alu_wait, ld_wait;
  int tag_idx [1 << `TAG_W];
  bit tag_live [1 << `TAG_W];
  bit issued [PROG_LEN];
  bit bcasted [PROG_LEN];
  bit hold_busy, hold_done, saw_full_stall, saw_pool_empty, timed_out;
  bit alu_busy_prev, ld_busy_prev, alu_was_taken, ld_was_taken;
  // pending unit results with tag, value and earliest request cycle
  int alu_q_tag[$], alu_q_due[$], ld_q_tag[$], ld_q_due[$];
  logic [`DATA_W-1:0] alu_q_val[$], ld_q_val[$];

  tomasulo_issue_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [`DATA_W-1:0] exp_v,
                                 input logic [`DATA_W-1:0] act_v);
    errors++;
    $display("[FAIL] t=%0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("[ERROR] t=%0t %s", $time, msg);
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    timed_out = 1'b1;
    $display("[ERROR] t=%0t timed out waiting for %s", $time, what);
  endtask

  // tags handed out and not yet broadcast
  function automatic int live_tags();
    int n;
    n = 0;
    for (int t = 1; t < (1 << `TAG_W); t++) begin
      if (tag_live[t]) n++;
    end
    return n;
  endfunction

  // accepted entries of one station that have not issued yet
  function automatic int station_count(input bit to_ld, input int upto);
    int n;
    n = 0;
    for (int j = 0; j < upto; j++) begin
      if (!issued[j] && ((prog[j].alu.opcode == OP_LD) == to_ld)) n++;
    end
    return n;
  endfunction

  // called at edge plus 1 and returns at edge plus 1 after acceptance
  task automatic send_instr(input int idx);
    int waited;
    int t;
    bit to_ld;
    int depth;
    waited = 0;
    to_ld = (prog[idx].alu.opcode == OP_LD);
    depth = to_ld ? `LD_RS_DEPTH : `ALU_RS_DEPTH;
    dispatch_valid = 1'b1;
    dispatch_instr = prog[idx];
    #5;
    while (dispatch_stall && !timed_out) begin
      if (hold_busy && station_count(to_ld, idx) == depth) begin
        saw_full_stall = 1'b1;
        hold_busy = 1'b0;
      end
      if (hold_done && live_tags() == (1 << `TAG_W) - 1) begin
        saw_pool_empty = 1'b1;
        hold_done = 1'b0;
      end
      waited++;
      if (waited > LIMIT) begin
        note_timeout($sformatf("dispatch of instruction %0d", idx));
      end
      @(posedge clk);
      #6;
    end
    if (!timed_out) begin
      t = DUT.u_dispatch_ctrl.alloc_tag;
      if (t == 0 || tag_live[t]) begin
        report_error($sformatf("tag %0d handed out while live or reserved", t));
      end
      tag_live[t] = 1'b1;
      tag_idx[t] = idx;
      dispatched++;
    end
    @(posedge clk);
    #1;
    dispatch_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (bcast_count < dispatched && !timed_out) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > LIMIT) begin
        note_timeout("all dispatched instructions to broadcast");
      end
    end
  endtask

  task automatic check_issue(input bit is_ld, input logic [`TAG_W-1:0] tag,
                             input opcode_t op, input logic [`DATA_W-1:0] a,
                             input logic [`DATA_W-1:0] b);
    int idx;
    if (!tag_live[tag]) begin
      report_error($sformatf("issue under tag %0d which is not live", tag));
    end else begin
      idx = tag_idx[tag];
      if (issued[idx]) begin
        report_error($sformatf("instruction %0d issued twice", idx));
      end
      if ((prog[idx].alu.opcode == OP_LD) != is_ld) begin
        report_error($sformatf("instruction %0d issued from the wrong station", idx));
      end
      if (!is_ld && op !== prog[idx].alu.opcode) begin
        report_mismatch("alu_issue_op", prog[idx].alu.opcode, op);
      end
      if (a !== exp_a[idx]) begin
        report_mismatch(is_ld ? "ld_issue_a" : "alu_issue_a", exp_a[idx], a);
      end
      if (b !== exp_b[idx]) begin
        report_mismatch(is_ld ? "ld_issue_b" : "alu_issue_b", exp_b[idx], b);
      end
      issued[idx] = 1'b1;
      if (is_ld) begin
        ld_q_tag.push_back(tag);
        ld_q_val.push_back(unit_result(OP_LD, a, b));
        ld_q_due.push_back(cycle + 1 + (($random(seed) & 32'h7fff_ffff) % 6));
      end else begin
        alu_q_tag.push_back(tag);
        alu_q_val.push_back(unit_result(op, a, b));
        alu_q_due.push_back(cycle + 1 + (($random(seed) & 32'h7fff_ffff) % 6));
      end
    end
  endtask

  // busy levels and done requests of the functional units at edge plus 1
  task automatic drive_units();
    alu_busy = hold_busy || (($random(seed) & 7) == 0);
    ld_busy  = hold_busy || (($random(seed) & 7) == 0);
    if (alu_done && alu_was_taken) alu_done = 1'b0;
    if (ld_done && ld_was_taken) ld_done = 1'b0;
    if (!alu_done && !hold_done) begin
      for (int k = 0; k < alu_q_tag.size(); k++) begin
        if (alu_q_due[k] <= cycle) begin
          alu_done = 1'b1;
          alu_done_tag = alu_q_tag[k];
          alu_done_value = alu_q_val[k];
          alu_q_tag.delete(k);
          alu_q_val.delete(k);
          alu_q_due.delete(k);
          alu_wait = 0;
          break;
        end
      end
    end
    if (!ld_done && !hold_done) begin
      for (int k = 0; k < ld_q_tag.size(); k++) begin
        if (ld_q_due[k] <= cycle) begin
          ld_done = 1'b1;
          ld_done_tag = ld_q_tag[k];
          ld_done_value = ld_q_val[k];
          ld_q_tag.delete(k);
          ld_q_val.delete(k);
          ld_q_due.delete(k);
          ld_wait = 0;
          break;
        end
      end
    end
  endtask

  // compare process at edge plus 7
  task automatic sample_and_check();
    int idx;
    alu_was_taken = alu_taken;
    ld_was_taken  = ld_taken;
    if (alu_taken && !alu_done) report_error("alu_taken pulsed with no request");
    if (ld_taken && !ld_done) report_error("ld_taken pulsed with no request");
    if (alu_done && !alu_taken) begin
      alu_wait++;
      if (alu_wait == 2) report_error("alu done request not taken within two cycles");
    end
    if (ld_done && !ld_taken) begin
      ld_wait++;
      if (ld_wait == 2) report_error("ld done request not taken within two cycles");
    end
    if (alu_issue_valid && alu_busy_prev) report_error("alu station issued while busy");
    if (ld_issue_valid && ld_busy_prev) report_error("load station issued while busy");
    alu_busy_prev = alu_busy;
    ld_busy_prev  = ld_busy;
    if (alu_issue_valid) check_issue(1'b0, alu_issue_tag, alu_issue_op, alu_issue_a, alu_issue_b);
    if (ld_issue_valid) check_issue(1'b1, ld_issue_tag, OP_LD, ld_issue_a, ld_issue_b);
    if (cdb_valid) begin
      if (!tag_live[cdb_tag]) begin
        report_error($sformatf("broadcast of tag %0d which is not live", cdb_tag));
      end else begin
        idx = tag_idx[cdb_tag];
        if (!issued[idx] || bcasted[idx]) begin
          report_error($sformatf("instruction %0d broadcast before issue or twice", idx));
        end
        if (cdb_value !== exp_res[idx]) report_mismatch("cdb_value", exp_res[idx], cdb_value);
        bcasted[idx] = 1'b1;
        tag_live[cdb_tag] = 1'b0;
        bcast_count++;
      end
    end
  endtask

  initial begin
    forever begin
      @(posedge clk);
      cycle++;
      #1;
      drive_units();
      #6;
      if (!rst) sample_and_check();
    end
  end

  initial begin
    rst = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_instr = '0;
    alu_busy = 1'b0;
    ld_busy = 1'b0;
    alu_done = 1'b0;
    alu_done_tag = '0;
    alu_done_value = '0;
    ld_done = 1'b0;
    ld_done_tag = '0;
    ld_done_value = '0;
    build_program();
    run_reference();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    #5;
    if (dispatch_stall) report_error("dispatch_stall high after reset");
    if (cdb_valid || alu_issue_valid || ld_issue_valid || alu_taken || ld_taken) begin
      report_error("issue, broadcast or taken active after reset");
    end
    @(posedge clk);
    #1;
    for (int i = 0; i < FINAL_AT; i++) begin
      // results held until the tag pool runs dry
      if (i == BURST_AT) hold_done = 1'b1;
      // both units busy until a station fills
      if (i == HOLD_AT) hold_busy = 1'b1;
      if (!timed_out) send_instr(i);
    end
    hold_busy = 1'b0;
    hold_done = 1'b0;
    wait_drain();
    for (int i = FINAL_AT; i < PROG_LEN; i++) begin
      if (!timed_out) send_instr(i);
    end
    wait_drain();
    if (!saw_full_stall) report_error("a full station never raised dispatch_stall");
    if (!saw_pool_empty) report_error("the tag pool never drained to zero");
    for (int i = 0; i < PROG_LEN; i++) begin
      if (!issued[i] || !bcasted[i]) begin
        report_error($sformatf("instruction %0d was lost", i));
      end
    end
    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== design/tomasulo_issue_top.sv ====
`timescale 1ns/100ps
`include "tomasulo_settings.svh"

module tomasulo_issue_top import tomasulo_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               dispatch_valid,
  input  instr_t             dispatch_instr,
  input  logic               alu_busy,
  input  logic               ld_busy,
  input  logic               alu_done,
  input  logic [`TAG_W-1:0]  alu_done_tag,
  input  logic [`DATA_W-1:0] alu_done_value,
  input  logic               ld_done,
  input  logic [`TAG_W-1:0]  ld_done_tag,
  input  logic [`DATA_W-1:0] ld_done_value,
  output logic               dispatch_stall,
  output logic               alu_issue_valid,
  output logic [`TAG_W-1:0]  alu_issue_tag,
  output opcode_t            alu_issue_op,
  output logic [`DATA_W-1:0] alu_issue_a,
  output logic [`DATA_W-1:0] alu_issue_b,
  output logic               ld_issue_valid,
  output logic [`TAG_W-1:0]  ld_issue_tag,
  output logic [`DATA_W-1:0] ld_issue_a,
  output logic [`DATA_W-1:0] ld_issue_b,
  output logic               alu_taken,
  output logic               ld_taken,
  output logic               cdb_valid,
  output logic [`TAG_W-1:0]  cdb_tag,
  output logic [`DATA_W-1:0] cdb_value
);

  logic              alu_write;
  logic              ld_write;
  logic              rename_write;
  logic [`TAG_W-1:0] alloc_tag;
  logic              alu_full;
  logic              ld_full;
  operand_t          rs1_opnd;
  operand_t          rs2_opnd;

  assign rename_write = alu_write || ld_write;

  dispatch_ctrl u_dispatch_ctrl (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_op    (dispatch_instr.alu.opcode),
    .alu_full       (alu_full),
    .ld_full        (ld_full),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .alu_write      (alu_write),
    .ld_write       (ld_write),
    .alloc_tag      (alloc_tag),
    .dispatch_stall (dispatch_stall)
  );

  rename_table u_rename_table (
    .clk          (clk),
    .rst          (rst),
    .instr        (dispatch_instr),
    .rename_write (rename_write),
    .alloc_tag    (alloc_tag),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .cdb_value    (cdb_value),
    .rs1_opnd     (rs1_opnd),
    .rs2_opnd     (rs2_opnd)
  );

  reservation_station #(.DEPTH(`ALU_RS_DEPTH)) alu_rs (
    .clk         (clk),
    .rst         (rst),
    .write       (alu_write),
    .write_tag   (alloc_tag),
    .write_op    (dispatch_instr.alu.opcode),
    .opnd_a      (rs1_opnd),
    .opnd_b      (rs2_opnd),
    .busy        (alu_busy),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .cdb_value   (cdb_value),
    .full        (alu_full),
    .issue_valid (alu_issue_valid),
    .issue_tag   (alu_issue_tag),
    .issue_op    (alu_issue_op),
    .issue_a     (alu_issue_a),
    .issue_b     (alu_issue_b)
  );

  // load unit only does address plus offset, op is not needed
  reservation_station #(.DEPTH(`LD_RS_DEPTH)) ld_rs (
    .clk         (clk),
    .rst         (rst),
    .write       (ld_write),
    .write_tag   (alloc_tag),
    .write_op    (dispatch_instr.ld.opcode),
    .opnd_a      (rs1_opnd),
    .opnd_b      (rs2_opnd),
    .busy        (ld_busy),
    .cdb_valid   (cdb_valid),
    .cdb_tag     (cdb_tag),
    .cdb_value   (cdb_value),
    .full        (ld_full),
    .issue_valid (ld_issue_valid),
    .issue_tag   (ld_issue_tag),
    .issue_op    (),
    .issue_a     (ld_issue_a),
    .issue_b     (ld_issue_b)
  );

  cdb_arbiter u_cdb_arbiter (
    .clk            (clk),
    .rst            (rst),
    .alu_done       (alu_done),
    .alu_done_tag   (alu_done_tag),
    .alu_done_value (alu_done_value),
    .ld_done        (ld_done),
    .ld_done_tag    (ld_done_tag),
    .ld_done_value  (ld_done_value),
    .alu_taken      (alu_taken),
    .ld_taken       (ld_taken),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag),
    .cdb_value      (cdb_value)
  );

endmodule

// ==== design/cdb_arbiter.sv ====
`timescale 1ns/100ps
`include "tomasulo_settings.svh"

module cdb_arbiter (
  input  logic               clk,
  input  logic               rst,
  input  logic               alu_done,
  input  logic [`TAG_W-1:0]  alu_done_tag,
  input  logic [`DATA_W-1:0] alu_done_value,
  input  logic               ld_done,
  input  logic [`TAG_W-1:0]  ld_done_tag,
  input  logic [`DATA_W-1:0] ld_done_value,
  output logic               alu_taken,
  output logic               ld_taken,
  output logic               cdb_valid,
  output logic [`TAG_W-1:0]  cdb_tag,
  output logic [`DATA_W-1:0] cdb_value
);

  // set after an alu grant so the load side wins the next tie
  logic prefer_ld;

  assign ld_taken  = ld_done && (!alu_done || prefer_ld);
  assign alu_taken = alu_done && !ld_taken;

  always_ff @(posedge clk) begin
    if (rst) begin
      prefer_ld <= 1'b0;
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= alu_taken || ld_taken;
      if (alu_taken) begin
        prefer_ld <= 1'b1;
      end else if (ld_taken) begin
        prefer_ld <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ld_taken) begin
      cdb_tag   <= ld_done_tag;
      cdb_value <= ld_done_value;
    end else if (alu_taken) begin
      cdb_tag   <= alu_done_tag;
      cdb_value <= alu_done_value;
    end
  end

endmodule

// ==== design/dispatch_ctrl.sv ====
`timescale 1ns/100ps
`include "tomasulo_settings.svh"

module dispatch_ctrl import tomasulo_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              dispatch_valid,
  input  opcode_t           dispatch_op,
  input  logic              alu_full,
  input  logic              ld_full,
  input  logic              cdb_valid,
  input  logic [`TAG_W-1:0] cdb_tag,
  output logic              alu_write,
  output logic              ld_write,
  output logic [`TAG_W-1:0] alloc_tag,
  output logic              dispatch_stall
);

  localparam int TW       = `TAG_W;
  localparam int NUM_TAGS = 1 << TW;

  // bit 0 stays clear, tag 0 is never handed out
  logic [NUM_TAGS-1:0] tag_busy;
  logic                tag_avail;
  logic                is_ld;
  logic                target_full;
  logic                accept;

  // lowest free tag
  always_comb begin
    alloc_tag = '0;
    tag_avail = 1'b0;
    for (int t = NUM_TAGS - 1; t >= 1; t--) begin
      if (!tag_busy[t]) begin
        alloc_tag = TW'(t);
        tag_avail = 1'b1;
      end
    end
  end

  assign is_ld          = (dispatch_op == OP_LD);
  assign target_full    = is_ld ? ld_full : alu_full;
  assign dispatch_stall = target_full || !tag_avail;
  assign accept         = dispatch_valid && !dispatch_stall;

  assign alu_write = accept && !is_ld;
  assign ld_write  = accept && is_ld;

  always_ff @(posedge clk) begin
    if (rst) begin
      tag_busy <= '0;
    end else begin
      // broadcast tag is still busy this cycle so it never equals alloc_tag
      if (cdb_valid) begin
        tag_busy[cdb_tag] <= 1'b0;
      end
      if (accept) begin
        tag_busy[alloc_tag] <= 1'b1;
      end
    end
  end

endmodule

// ==== design/reservation_station.sv ====
`timescale 1ns/100ps
`include "tomasulo_settings.svh"

module reservation_station import tomasulo_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               write,
  input  logic [`TAG_W-1:0]  write_tag,
  input  opcode_t            write_op,
  input  operand_t           opnd_a,
  input  operand_t           opnd_b,
  input  logic               busy,
  input  logic               cdb_valid,
  input  logic [`TAG_W-1:0]  cdb_tag,
  input  logic [`DATA_W-1:0] cdb_value,
  output logic               full,
  output logic               issue_valid,
  output logic [`TAG_W-1:0]  issue_tag,
  output opcode_t            issue_op,
  output logic [`DATA_W-1:0] issue_a,
  output logic [`DATA_W-1:0] issue_b
);

  localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // age counts the live entries younger than this one
  localparam int AGE_W = IDX_W;

  logic [DEPTH-1:0]  ent_valid;
  logic [`TAG_W-1:0] ent_tag [DEPTH];
  opcode_t           ent_op  [DEPTH];
  operand_t          ent_a   [DEPTH];
  operand_t          ent_b   [DEPTH];
  logic [AGE_W-1:0]  ent_age [DEPTH];

  logic [DEPTH-1:0]  ready;
  logic              sel_found;
  logic [IDX_W-1:0]  sel_idx;
  logic [AGE_W-1:0]  sel_age;
  logic [IDX_W-1:0]  wr_idx;
  logic              do_issue;

  assign full = &ent_valid;

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      ready[i] = ent_valid[i] && (ent_a[i].tag == '0) && (ent_b[i].tag == '0);
    end
  end

  // oldest ready entry
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    sel_age   = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (ready[i] && (!sel_found || ent_age[i] > sel_age)) begin
        sel_found = 1'b1;
        sel_idx   = IDX_W'(i);
        sel_age   = ent_age[i];
      end
    end
  end

  // lowest empty slot
  always_comb begin
    wr_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        wr_idx = IDX_W'(i);
      end
    end
  end

  assign do_issue = sel_found && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      ent_valid   <= '0;
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= do_issue;
      if (do_issue) begin
        ent_valid[sel_idx] <= 1'b0;
      end
      if (write) begin
        ent_valid[wr_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      // operand wake-up from the bus
      if (cdb_valid && ent_a[i].tag != '0 && ent_a[i].tag == cdb_tag) begin
        ent_a[i].value <= cdb_value;
        ent_a[i].tag   <= '0;
      end
      if (cdb_valid && ent_b[i].tag != '0 && ent_b[i].tag == cdb_tag) begin
        ent_b[i].value <= cdb_value;
        ent_b[i].tag   <= '0;
      end
      if (ent_valid[i]) begin
        ent_age[i] <= ent_age[i] + AGE_W'(write)
                      - AGE_W'(do_issue && (ent_age[i] > sel_age));
      end
    end
    if (write) begin
      ent_tag[wr_idx] <= write_tag;
      ent_op[wr_idx]  <= write_op;
      ent_a[wr_idx]   <= opnd_a;
      ent_b[wr_idx]   <= opnd_b;
      ent_age[wr_idx] <= '0;
    end
    if (do_issue) begin
      issue_tag <= ent_tag[sel_idx];
      issue_op  <= ent_op[sel_idx];
      issue_a   <= ent_a[sel_idx].value;
      issue_b   <= ent_b[sel_idx].value;
    end
  end

endmodule

// ==== design/rename_table.sv ====
`timescale 1ns/100ps
`include "tomasulo_settings.svh"

module rename_table import tomasulo_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  instr_t             instr,
  input  logic               rename_write,
  input  logic [`TAG_W-1:0]  alloc_tag,
  input  logic               cdb_valid,
  input  logic [`TAG_W-1:0]  cdb_tag,
  input  logic [`DATA_W-1:0] cdb_value,
  output operand_t           rs1_opnd,
  output operand_t           rs2_opnd
);

  logic [`DATA_W-1:0] reg_value [`NUM_REGS];
  logic [`TAG_W-1:0]  reg_tag   [`NUM_REGS];
  logic               is_ld;
  logic [`REG_W-1:0]  src1;
  logic [`REG_W-1:0]  src2;

  // pending register whose producer is on the bus reads the bus value
  function automatic operand_t read_opnd(input logic [`DATA_W-1:0] value,
                                         input logic [`TAG_W-1:0]  tag);
    operand_t opnd;
    if (tag != '0 && cdb_valid && cdb_tag == tag) begin
      opnd.value = cdb_value;
      opnd.tag   = '0;
    end else begin
      opnd.value = value;
      opnd.tag   = tag;
    end
    return opnd;
  endfunction

  assign is_ld = (instr.alu.opcode == OP_LD);
  // ld.base sits on the same bits as alu.rs1
  assign src1  = instr.alu.rs1;
  assign src2  = instr.alu.rs2;

  always_comb begin
    rs1_opnd = read_opnd(reg_value[src1], reg_tag[src1]);
    if (is_ld) begin
      // offset goes out as an immediate
      rs2_opnd.value = {{(`DATA_W - OFFSET_W){1'b0}}, instr.ld.offset};
      rs2_opnd.tag   = '0;
    end else begin
      rs2_opnd = read_opnd(reg_value[src2], reg_tag[src2]);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        reg_value[i] <= '0;
        reg_tag[i]   <= '0;
      end
    end else begin
      // writeback only where the register still waits on this tag
      for (int i = 0; i < `NUM_REGS; i++) begin
        if (cdb_valid && reg_tag[i] != '0 && reg_tag[i] == cdb_tag) begin
          reg_value[i] <= cdb_value;
          reg_tag[i]   <= '0;
        end
      end
      // a new rename of the same register overrides the writeback
      if (rename_write) begin
        reg_tag[instr.alu.rd] <= alloc_tag;
      end
    end
  end

endmodule

// ==== design/tomasulo_pkg.sv ====
`include "tomasulo_settings.svh"

package tomasulo_pkg;

  localparam int INSTR_W  = 16;
  localparam int OPCODE_W = 3;
  // bits left over once the two register fields are placed
  localparam int OFFSET_W = INSTR_W - OPCODE_W - 2 * `REG_W;
  localparam int SPARE_W  = INSTR_W - OPCODE_W - 3 * `REG_W;

  typedef enum logic [OPCODE_W-1:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_XOR = 3'd3,
    OP_LD  = 3'd4
  } opcode_t;

  typedef struct packed {
    opcode_t           opcode;
    logic [`REG_W-1:0] rd;
    logic [`REG_W-1:0] rs1;
    logic [`REG_W-1:0] rs2;
    logic [SPARE_W-1:0] spare;
  } alu_fmt_t;

  // load address is base register plus unsigned offset
  typedef struct packed {
    opcode_t            opcode;
    logic [`REG_W-1:0]  rd;
    logic [`REG_W-1:0]  base;
    logic [OFFSET_W-1:0] offset;
  } ld_fmt_t;

  typedef union packed {
    alu_fmt_t alu;
    ld_fmt_t  ld;
  } instr_t;

  // tag of zero means the value is valid
  typedef struct packed {
    logic [`DATA_W-1:0] value;
    logic [`TAG_W-1:0]  tag;
  } operand_t;

endpackage

// ==== include/tomasulo_settings.svh ====
`ifndef TOMASULO_SETTINGS_SVH
`define TOMASULO_SETTINGS_SVH

// architectural register file
`define NUM_REGS 16
`define REG_W 4

// reorder tags (tag 0 is reserved to mean no tag)
`define TAG_W 4

// operand and result width
`define DATA_W 32

// reservation station entries
`define ALU_RS_DEPTH 4
`define LD_RS_DEPTH 2

`endif
